// ==== decode_pkg.sv ====
package decode_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [1:0] op_len_t;

	////////////////////////////////////////////////////////////
	// alu operation classes
	////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		ALU_ADD    = 6'd0,
		ALU_ADDC   = 6'd1,
		ALU_SUBB   = 6'd2,
		ALU_INC    = 6'd3,
		ALU_DEC    = 6'd4,
		ALU_ANL    = 6'd16,
		ALU_ORL    = 6'd17,
		ALU_XRL    = 6'd18,
		ALU_ANL_DA = 6'd20,
		ALU_ORL_DA = 6'd21,
		ALU_XRL_DA = 6'd22,
		ALU_LJMP   = 6'd36,
		ALU_SJMP   = 6'd37,
		ALU_CJNE_D = 6'd39,
		ALU_DJNZ   = 6'd40,
		ALU_JZ     = 6'd41,
		ALU_JNZ    = 6'd42,
		ALU_JC     = 6'd43,
		ALU_JNC    = 6'd44,
		ALU_JB     = 6'd45,
		ALU_JNB    = 6'd46,
		ALU_JBC    = 6'd47,
		ALU_CJNE_C = 6'd48,
		ALU_CJNE_R = 6'd49,
		ALU_CJNE_I = 6'd50,
		ALU_NONE   = 6'd63
	} alu_op_t;

	// short takes its offset from ins1, long from ins2
	typedef enum logic [1:0] {
		BR_NONE      = 2'd0,
		BR_REL_LONG  = 2'd1,
		BR_REL_SHORT = 2'd2,
		BR_ABS       = 2'd3
	} pc_branch_t;

	////////////////////////////////////////////////////////////
	// opcodes
	////////////////////////////////////////////////////////////

	localparam byte_t OP_NOP    = 8'h00;
	localparam byte_t OP_LJMP   = 8'h02;
	localparam byte_t OP_JBC    = 8'h10;
	localparam byte_t OP_JB     = 8'h20;
	localparam byte_t OP_JNB    = 8'h30;
	localparam byte_t OP_JC     = 8'h40;
	localparam byte_t OP_JNC    = 8'h50;
	localparam byte_t OP_JZ     = 8'h60;
	localparam byte_t OP_JNZ    = 8'h70;
	localparam byte_t OP_SJMP   = 8'h80;
	localparam byte_t OP_CJNE_C = 8'hb4;
	localparam byte_t OP_CJNE_D = 8'hb5;
	localparam byte_t OP_CJNE_I = 8'hb6;
	localparam byte_t OP_CJNE_R = 8'hb8;
	localparam byte_t OP_DJNZ_D = 8'hd5;
	localparam byte_t OP_DJNZ_R = 8'hd8;

	// group bases, low nibble gives the operand form
	localparam byte_t OP_INC    = 8'h00;
	localparam byte_t OP_DEC    = 8'h10;
	localparam byte_t OP_ADD    = 8'h20;
	localparam byte_t OP_ADDC   = 8'h30;
	localparam byte_t OP_ORL    = 8'h40;
	localparam byte_t OP_ANL    = 8'h50;
	localparam byte_t OP_XRL    = 8'h60;
	localparam byte_t OP_SUBB   = 8'h90;

	// branches that wait for the execute stage outcome
	function automatic logic is_cond_branch(input byte_t op);
		logic cjne;
		logic djnz;
		cjne = (op[7:4] == OP_CJNE_C[7:4]) && (op[3:0] >= 4'h4);
		djnz = (op == OP_DJNZ_D) || (op[7:3] == OP_DJNZ_R[7:3]);
		return cjne || djnz ||
			(op inside {OP_JBC, OP_JB, OP_JNB, OP_JC, OP_JNC, OP_JZ, OP_JNZ});
	endfunction

endpackage

// ==== instr_length_decode.sv ====
`timescale 1ns/1ps

module instr_length_decode (
	input  decode_pkg::byte_t   ins0,
	output decode_pkg::op_len_t op_length
);
	import decode_pkg::*;

	logic [3:0] grp;
	logic [3:0] form;
	logic       acc_group;
	logic       incdec_group;
	logic       cjne;
	logic       djnz_r;
	logic       logic_da;

	assign grp  = ins0[7:4];
	assign form = ins0[3:0];

	// accumulator arithmetic and logic groups
	assign acc_group = grp inside {OP_ADD[7:4], OP_ADDC[7:4], OP_SUBB[7:4],
		OP_ORL[7:4], OP_ANL[7:4], OP_XRL[7:4]};

	assign incdec_group = (grp == OP_INC[7:4]) || (grp == OP_DEC[7:4]);

	// b4 to bf
	assign cjne = (grp == OP_CJNE_C[7:4]) && (form >= 4'h4);

	assign djnz_r = (ins0[7:3] == OP_DJNZ_R[7:3]);

	// direct,A forms of the logic ops
	assign logic_da = (form == 4'h2) &&
		(grp inside {OP_ORL[7:4], OP_ANL[7:4], OP_XRL[7:4]});

	////////////////////////////////////////////////////////////
	// length table
	////////////////////////////////////////////////////////////

	always_comb begin
		op_length = 2'd1;
		if (cjne || (ins0 inside {OP_LJMP, OP_JBC, OP_JB, OP_JNB, OP_DJNZ_D})) begin
			op_length = 2'd3;
		end else if (ins0 inside {OP_JC, OP_JNC, OP_JZ, OP_JNZ, OP_SJMP}) begin
			op_length = 2'd2;
		end else if (djnz_r || logic_da) begin
			op_length = 2'd2;
		end else if (acc_group && ((form == 4'h4) || (form == 4'h5))) begin
			// #data and direct
			op_length = 2'd2;
		end else if (incdec_group && (form == 4'h5)) begin
			op_length = 2'd2;
		end
	end

endmodule

// ==== alu_op_decode.sv ====
`timescale 1ns/1ps

module alu_op_decode (
	input  decode_pkg::byte_t   ins0,
	output decode_pkg::alu_op_t alu
);
	import decode_pkg::*;

	logic [3:0] grp;
	logic [3:0] form;

	assign grp  = ins0[7:4];
	assign form = ins0[3:0];

	////////////////////////////////////////////////////////////
	// exact opcodes first, then the grouped forms
	////////////////////////////////////////////////////////////

	always_comb begin
		alu = ALU_NONE;
		case (ins0)
			OP_LJMP:   alu = ALU_LJMP;
			OP_SJMP:   alu = ALU_SJMP;
			OP_JZ:     alu = ALU_JZ;
			OP_JNZ:    alu = ALU_JNZ;
			OP_JC:     alu = ALU_JC;
			OP_JNC:    alu = ALU_JNC;
			OP_JB:     alu = ALU_JB;
			OP_JNB:    alu = ALU_JNB;
			OP_JBC:    alu = ALU_JBC;
			OP_CJNE_C: alu = ALU_CJNE_C;
			OP_CJNE_D: alu = ALU_CJNE_D;
			OP_DJNZ_D: alu = ALU_DJNZ;

			// direct,A logic forms
			{OP_ANL[7:4], 4'h2}: alu = ALU_ANL_DA;
			{OP_ORL[7:4], 4'h2}: alu = ALU_ORL_DA;
			{OP_XRL[7:4], 4'h2}: alu = ALU_XRL_DA;

			default: begin
				// forms 4 to f share the class of their group
				if (form >= 4'h4) begin
					case (grp)
						OP_INC[7:4]:  alu = ALU_INC;
						OP_DEC[7:4]:  alu = ALU_DEC;
						OP_ADD[7:4]:  alu = ALU_ADD;
						OP_ADDC[7:4]: alu = ALU_ADDC;
						OP_SUBB[7:4]: alu = ALU_SUBB;
						OP_ANL[7:4]:  alu = ALU_ANL;
						OP_ORL[7:4]:  alu = ALU_ORL;
						OP_XRL[7:4]:  alu = ALU_XRL;
						OP_CJNE_I[7:4]: begin
							// b6/b7 are @Ri, b8 up are Rn
							if (form < OP_CJNE_R[3:0]) begin
								alu = ALU_CJNE_I;
							end else begin
								alu = ALU_CJNE_R;
							end
						end
						OP_DJNZ_R[7:4]: begin
							if (form >= OP_DJNZ_R[3:0]) begin
								alu = ALU_DJNZ;
							end
						end
						default: alu = ALU_NONE;
					endcase
				end
			end
		endcase
	end

endmodule

// ==== branch_ctrl.sv ====
`timescale 1ns/1ps

module branch_ctrl (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   stall_addr,
	input  logic                   branch_valid,
	input  logic                   branch_test,
	input  decode_pkg::byte_t      ins0,
	input  decode_pkg::byte_t      ins1,
	input  decode_pkg::byte_t      ins2,
	output decode_pkg::pc_branch_t pc_branch,
	output decode_pkg::byte_t      pc_reladdr,
	output logic [15:0]            pc_absaddr,
	output logic                   flush,
	output logic                   stall
);
	import decode_pkg::*;

	typedef enum logic {
		IDLE,
		WAIT
	} state_t;

	state_t state;
	state_t next_state;
	logic   short_rel;

	////////////////////////////////////////////////////////////
	// wait for branch outcome
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (!stall_addr && is_cond_branch(ins0)) begin
					next_state = WAIT;
				end
			end
			WAIT: begin
				if (branch_valid) begin
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	// rises with the branch, drops in the outcome cycle
	assign stall = (next_state == WAIT);

	////////////////////////////////////////////////////////////
	// pc redirect
	////////////////////////////////////////////////////////////

	// two-byte branches carry the offset in ins1
	assign short_rel = (ins0 inside {OP_JC, OP_JNC, OP_JZ, OP_JNZ}) ||
		(ins0[7:3] == OP_DJNZ_R[7:3]);

	always_comb begin
		flush      = 1'b0;
		pc_branch  = BR_NONE;
		pc_reladdr = 8'h00;
		pc_absaddr = 16'h0000;
		if (branch_valid && branch_test) begin
			// taken, drop the younger bytes
			flush = 1'b1;
			if (short_rel) begin
				pc_branch  = BR_REL_SHORT;
				pc_reladdr = ins1;
			end else begin
				pc_branch  = BR_REL_LONG;
				pc_reladdr = ins2;
			end
		end else if (ins0 == OP_SJMP) begin
			pc_branch  = BR_REL_SHORT;
			pc_reladdr = ins1;
		end else if (ins0 == OP_LJMP) begin
			pc_branch  = BR_ABS;
			pc_absaddr = {ins1, ins2};
		end
	end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                   clk,
	input  logic                   rst,
	input  decode_pkg::byte_t      ins0,
	input  decode_pkg::byte_t      ins1,
	input  decode_pkg::byte_t      ins2,
	input  logic                   stall_addr,
	input  logic                   branch_valid,
	input  logic                   branch_test,
	output decode_pkg::op_len_t    op_length,
	output decode_pkg::alu_op_t    alu,
	output decode_pkg::pc_branch_t pc_branch,
	output decode_pkg::byte_t      pc_reladdr,
	output logic [15:0]            pc_absaddr,
	output logic                   flush,
	output logic                   stall,
	output logic                   nop_dec
);
	import decode_pkg::*;

	instr_length_decode u_len (
		.ins0      (ins0),
		.op_length (op_length)
	);

	alu_op_decode u_alu (
		.ins0 (ins0),
		.alu  (alu)
	);

	branch_ctrl u_branch (
		.clk          (clk),
		.rst          (rst),
		.stall_addr   (stall_addr),
		.branch_valid (branch_valid),
		.branch_test  (branch_test),
		.ins0         (ins0),
		.ins1         (ins1),
		.ins2         (ins2),
		.pc_branch    (pc_branch),
		.pc_reladdr   (pc_reladdr),
		.pc_absaddr   (pc_absaddr),
		.flush        (flush),
		.stall        (stall)
	);

	// bubble for the hazard unit, ljmp resolves here
	assign nop_dec = (ins0 == OP_NOP) || (ins0 == OP_LJMP);

endmodule

// ==== tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage;
	import decode_pkg::*;

	// two sweeps of 512 plus 200 trials of up to 12 cycles, with margin
	localparam int TIMEOUT_CYCLES = 6000;

	logic       clk = 1'b0;
	logic       rst = 1'b1;
	byte_t      ins0 = 8'h00;
	byte_t      ins1 = 8'h00;
	byte_t      ins2 = 8'h00;
	logic       stall_addr = 1'b1;
	logic       branch_valid = 1'b0;
	logic       branch_test = 1'b0;
	op_len_t    op_length;
	alu_op_t    alu;
	pc_branch_t pc_branch;
	byte_t      pc_reladdr;
	logic [15:0] pc_absaddr;
	logic       flush;
	logic       stall;
	logic       nop_dec;

	int          cycles = 0;
	logic        model_wait = 1'b0;
	logic        exp_next;
	logic [26:0] exp_redir;

	decode_stage UUT (
		.clk          (clk),
		.rst          (rst),
		.ins0         (ins0),
		.ins1         (ins1),
		.ins2         (ins2),
		.stall_addr   (stall_addr),
		.branch_valid (branch_valid),
		.branch_test  (branch_test),
		.op_length    (op_length),
		.alu          (alu),
		.pc_branch    (pc_branch),
		.pc_reladdr   (pc_reladdr),
		.pc_absaddr   (pc_absaddr),
		.flush        (flush),
		.stall        (stall),
		.nop_dec      (nop_dec)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic op_len_t ref_length(input byte_t op);
		if ((op inside {8'h02, 8'h10, 8'h20, 8'h30, 8'hd5}) || (op[7:4] == 4'hb && op[3:0] >= 4'h4))
			return 2'd3;
		if ((op inside {8'h40, 8'h50, 8'h60, 8'h70, 8'h80, 8'h42, 8'h52, 8'h62}) ||
			(op[7:4] == 4'hd && op[3:0] >= 4'h8))
			return 2'd2;
		if ((op[7:4] inside {4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h9}) && (op[3:0] inside {4'h4, 4'h5}))
			return 2'd2;
		// inc/dec direct
		if ((op[7:4] inside {4'h0, 4'h1}) && op[3:0] == 4'h5)
			return 2'd2;
		return 2'd1;
	endfunction

	function automatic alu_op_t ref_alu(input byte_t op);
		case (op)
			8'h02: return ALU_LJMP;
			8'h80: return ALU_SJMP;
			8'h60: return ALU_JZ;
			8'h70: return ALU_JNZ;
			8'h40: return ALU_JC;
			8'h50: return ALU_JNC;
			8'h20: return ALU_JB;
			8'h30: return ALU_JNB;
			8'h10: return ALU_JBC;
			8'hb4: return ALU_CJNE_C;
			8'hb5: return ALU_CJNE_D;
			8'hb6, 8'hb7: return ALU_CJNE_I;
			8'hd5: return ALU_DJNZ;
			8'h52: return ALU_ANL_DA;
			8'h42: return ALU_ORL_DA;
			8'h62: return ALU_XRL_DA;
			default: ;
		endcase
		if (op[7:4] == 4'hb && op[3:0] >= 4'h8)
			return ALU_CJNE_R;
		if (op[7:4] == 4'hd && op[3:0] >= 4'h8)
			return ALU_DJNZ;
		if (op[3:0] < 4'h4)
			return ALU_NONE;
		case (op[7:4])
			4'h0: return ALU_INC;
			4'h1: return ALU_DEC;
			4'h2: return ALU_ADD;
			4'h3: return ALU_ADDC;
			4'h9: return ALU_SUBB;
			4'h5: return ALU_ANL;
			4'h4: return ALU_ORL;
			4'h6: return ALU_XRL;
			default: return ALU_NONE;
		endcase
	endfunction

	function automatic logic ref_cond(input byte_t op);
		return (op inside {8'h10, 8'h20, 8'h30, 8'h40, 8'h50, 8'h60, 8'h70, 8'hd5}) ||
			(op[7:4] == 4'hb && op[3:0] >= 4'h4) || (op[7:4] == 4'hd && op[3:0] >= 4'h8);
	endfunction

	function automatic logic ref_next_wait(input logic in_wait, input byte_t op,
		input logic sa, input logic bv);
		if (!in_wait)
			return !sa && ref_cond(op);
		return !bv;
	endfunction

	// packed as {flush, kind, reladdr, absaddr}
	function automatic logic [26:0] ref_redirect(input byte_t op, input byte_t b1,
		input byte_t b2, input logic bv, input logic bt);
		logic short_rel;
		short_rel = (op inside {8'h40, 8'h50, 8'h60, 8'h70}) || (op[7:4] == 4'hd && op[3:0] >= 4'h8);
		if (bv && bt)
			return short_rel ? {1'b1, BR_REL_SHORT, b1, 16'h0000} : {1'b1, BR_REL_LONG, b2, 16'h0000};
		if (op == 8'h80)
			return {1'b0, BR_REL_SHORT, b1, 16'h0000};
		if (op == 8'h02)
			return {1'b0, BR_ABS, 8'h00, b1, b2};
		return {1'b0, BR_NONE, 8'h00, 16'h0000};
	endfunction

	task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// compare at the falling edge, inputs are settled by then
	always @(negedge clk) begin
		if (rst) begin
			model_wait = 1'b0;
		end else begin
			exp_next = ref_next_wait(model_wait, ins0, stall_addr, branch_valid);
			exp_redir = ref_redirect(ins0, ins1, ins2, branch_valid, branch_test);
			check("op_length", 32'(op_length), 32'(ref_length(ins0)));
			check("alu", 32'(alu), 32'(ref_alu(ins0)));
			check("nop_dec", 32'(nop_dec), 32'(ins0 == 8'h00 || ins0 == 8'h02));
			check("stall", 32'(stall), 32'(exp_next));
			check("flush", 32'(flush), 32'(exp_redir[26]));
			check("pc_branch", 32'(pc_branch), 32'(exp_redir[25:24]));
			check("pc_reladdr", 32'(pc_reladdr), 32'(exp_redir[23:16]));
			check("pc_absaddr", 32'(pc_absaddr), 32'(exp_redir[15:0]));
			model_wait = exp_next;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic drive(input byte_t op, input byte_t b1, input byte_t b2,
		input logic sa, input logic bv, input logic bt);
		@(posedge clk);
		#1;
		ins0 = op;
		ins1 = b1;
		ins2 = b2;
		stall_addr = sa;
		branch_valid = bv;
		branch_test = bt;
	endtask

	initial begin
		byte_t op;
		int    delay;
		void'($urandom(85));
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		drive(8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0);

		// opcode sweeps held in idle, the second with a resolved outcome on every cycle
		for (int i = 0; i < 256; i++) begin
			drive(8'(i), 8'($urandom), 8'($urandom), 1'b1, 1'b0, 1'b0);
		end
		for (int i = 0; i < 256; i++) begin
			drive(8'(i), 8'($urandom), 8'($urandom), 1'b1, 1'b1, 1'($urandom));
		end

		// conditional branches waiting on the execute stage
		for (int t = 0; t < 200; t++) begin
			op = 8'($urandom);
			while (!ref_cond(op)) begin
				op = 8'($urandom);
			end
			delay = $urandom % 9;
			drive(op, 8'($urandom), 8'($urandom), 1'b0, 1'b0, 1'b0);
			repeat (delay) drive(op, ins1, ins2, 1'b0, 1'b0, 1'b0);
			drive(op, ins1, ins2, 1'b0, 1'b1, 1'($urandom));
			drive(8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0);
		end

		// stall_addr holds off the wait
		drive(8'h60, 8'h12, 8'h34, 1'b1, 1'b0, 1'b0);
		drive(8'h60, 8'h12, 8'h34, 1'b1, 1'b0, 1'b0);
		drive(8'h60, 8'h12, 8'h34, 1'b0, 1'b0, 1'b0);
		drive(8'h60, 8'h12, 8'h34, 1'b0, 1'b1, 1'b1);
		drive(8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0);
		@(posedge clk);
		#1;

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
decode_pkg.sv
instr_length_decode.sv
alu_op_decode.sv
branch_ctrl.sv
decode_stage.sv
tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f filelist.f --top-module tb_decode_stage -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
echo "simulation finished, see sim.log"
